// File: pivot_row_select.f
rtl/pivot_row_pkg.sv
rtl/row_screener.sv
rtl/candidate_fifo.sv
rtl/ratio_tracker.sv
rtl/pivot_row_select.sv
testbench/tb_clock_gen.sv
testbench/pivot_row_checker.sv
testbench/tb_pivot_row_select.sv

// File: rtl/candidate_fifo.sv
`timescale 1ns/1ps

module candidate_fifo (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             push,
    input  logic [pivot_row_pkg::cand_w-1:0] push_data,
    input  logic                             pop,
    output logic [pivot_row_pkg::cand_w-1:0] pop_data,
    output logic                             full,
    output logic                             empty
);
    import pivot_row_pkg::*;

    logic [cand_w-1:0]     mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;           // entries held
    logic                  do_push;
    logic                  do_pop;

    assign full     = (count == fifo_cnt_w'(fifo_depth));
    assign empty    = (count == '0);
    assign do_push  = push && !full;        // overflow ignored
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];          // head visible the cycle after push

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: rtl/pivot_row_pkg.sv
package pivot_row_pkg;

    // data widths
    localparam int coef_w = 16;                  // signed pivot / rhs value
    localparam int idx_w  = 16;                  // row index and row count
    localparam int prod_w = 2 * coef_w;          // full cross product

    // candidate buffer
    localparam int fifo_depth  = 4;
    localparam int fifo_ptr_w  = $clog2(fifo_depth);
    localparam int fifo_cnt_w  = $clog2(fifo_depth + 1);   // must hold fifo_depth itself

    // candidate entry, {idx, pivot, rhs} from msb down
    localparam int cand_w       = idx_w + 2 * coef_w;
    localparam int cand_rhs_lsb = 0;
    localparam int cand_piv_lsb = coef_w;
    localparam int cand_idx_lsb = 2 * coef_w;

    // wishbone word addresses, any read returns status
    localparam logic adr_count = 1'b0;           // load row count, start search
    localparam logic adr_row   = 1'b1;           // one row word

    // status word bits
    localparam int stat_done_bit  = 31;
    localparam int stat_found_bit = 30;

    typedef logic signed [coef_w-1:0] coef_t;
    typedef logic        [idx_w-1:0]  idx_t;
    typedef logic signed [prod_w-1:0] prod_t;

endpackage

// File: rtl/pivot_row_select.sv
`timescale 1ns/1ps

module pivot_row_select (
    input  logic        clk,
    input  logic        resetn,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic        wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);
    import pivot_row_pkg::*;

    logic              push;         // screener -> fifo
    logic [cand_w-1:0] push_data;
    logic              full;
    logic              empty;        // fifo -> tracker
    logic [cand_w-1:0] pop_data;
    logic              pop;
    logic              search_start; // screener -> tracker
    logic              rows_all_in;
    logic              done;         // tracker -> status read
    logic              found;
    idx_t              best_idx;

    row_screener u_row_screener (
        .clk          (clk),
        .resetn       (resetn),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .full         (full),
        .done         (done),
        .found        (found),
        .best_idx     (best_idx),
        .push         (push),
        .push_data    (push_data),
        .search_start (search_start),
        .rows_all_in  (rows_all_in)
    );

    candidate_fifo u_candidate_fifo (
        .clk       (clk),
        .resetn    (resetn),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    ratio_tracker u_ratio_tracker (
        .clk          (clk),
        .resetn       (resetn),
        .empty        (empty),
        .pop_data     (pop_data),
        .search_start (search_start),
        .rows_all_in  (rows_all_in),
        .pop          (pop),
        .done         (done),
        .found        (found),
        .best_idx     (best_idx)
    );

endmodule

// File: rtl/ratio_tracker.sv
`timescale 1ns/1ps

module ratio_tracker (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             empty,
    input  logic [pivot_row_pkg::cand_w-1:0] pop_data,
    input  logic                             search_start,
    input  logic                             rows_all_in,
    output logic                             pop,
    output logic                             done,
    output logic                             found,
    output pivot_row_pkg::idx_t              best_idx
);
    import pivot_row_pkg::*;

    idx_t  cand_idx;
    coef_t cand_piv;
    coef_t cand_rhs;
    coef_t best_piv;                 // pivot of current best row
    coef_t best_rhs;                 // rhs of current best row
    logic  s1_valid;                 // stage one holds a candidate
    prod_t s1_prod_new;              // new rhs * best pivot
    prod_t s1_prod_best;             // best rhs * new pivot
    idx_t  s1_idx;
    coef_t s1_piv;
    coef_t s1_rhs;
    logic  take_new;

    assign cand_idx = pop_data[cand_idx_lsb +: idx_w];
    assign cand_piv = pop_data[cand_piv_lsb +: coef_w];
    assign cand_rhs = pop_data[cand_rhs_lsb +: coef_w];

    // one in flight, next pop sees the updated best
    assign pop = !empty && !s1_valid;

    // pivots are positive so rhs_n/piv_n < rhs_b/piv_b iff rhs_n*piv_b < rhs_b*piv_n
    // strict less keeps the earlier row on a tie
    assign take_new = s1_valid && (!found || (s1_prod_new < s1_prod_best));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
            found    <= 1'b0;
            best_idx <= '0;
            done     <= 1'b0;
        end else if (search_start) begin
            s1_valid <= 1'b0;        // flush anything left from an old search
            found    <= 1'b0;
            best_idx <= '0;
            done     <= 1'b0;
        end else begin
            s1_valid <= pop;
            if (take_new) begin      // stage two commits as stage one retires
                found    <= 1'b1;
                best_idx <= s1_idx;
            end
            // pipeline drained and no more rows coming
            if (rows_all_in && empty && !s1_valid) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            s1_prod_new  <= cand_rhs * best_piv;
            s1_prod_best <= best_rhs * cand_piv;
            s1_idx       <= cand_idx;
            s1_piv       <= cand_piv;
            s1_rhs       <= cand_rhs;
        end
        if (take_new) begin
            best_piv <= s1_piv;
            best_rhs <= s1_rhs;
        end
    end

endmodule

// File: rtl/row_screener.sv
`timescale 1ns/1ps

module row_screener (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic                             wb_adr,
    input  logic [31:0]                      wb_dat_w,
    output logic [31:0]                      wb_dat_r,
    output logic                             wb_ack,
    input  logic                             full,
    input  logic                             done,
    input  logic                             found,
    input  pivot_row_pkg::idx_t              best_idx,
    output logic                             push,
    output logic [pivot_row_pkg::cand_w-1:0] push_data,
    output logic                             search_start,
    output logic                             rows_all_in
);
    import pivot_row_pkg::*;

    idx_t        row_count;                      // rows expected this search
    idx_t        row_idx;                        // index of next row word
    logic        search_live;                    // a count has been written
    logic        req;
    logic        count_wr;
    logic        row_wr;
    logic        rd;
    coef_t       row_piv;
    coef_t       row_rhs;
    logic        row_pass;
    logic [31:0] stat_word;

    // new request only while not already acking, keeps ack to one cycle
    assign req      = wb_cyc && wb_stb && !wb_ack;
    assign count_wr = req && wb_we && (wb_adr == adr_count);
    assign row_wr   = req && wb_we && (wb_adr == adr_row) && !full;   // stall on full fifo
    assign rd       = req && !wb_we;

    assign row_piv = wb_dat_w[2*coef_w-1:coef_w];                // pivot in upper half
    assign row_rhs = wb_dat_w[coef_w-1:0];                       // rhs in lower half

    // simplex rule, rows past the count are acked but dropped
    assign row_pass = (row_piv > 0) && (row_rhs >= 0) && (row_idx < row_count);

    always_comb begin
        stat_word                 = '0;
        stat_word[stat_done_bit]  = done;
        stat_word[stat_found_bit] = found;
        stat_word[idx_w-1:0]      = found ? best_idx : '0;   // index only valid with found
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_ack       <= 1'b0;
            push         <= 1'b0;
            search_start <= 1'b0;
            rows_all_in  <= 1'b0;
            search_live  <= 1'b0;
            row_count    <= '0;
            row_idx      <= '0;
        end else begin
            wb_ack       <= count_wr || row_wr || rd;   // ack one cycle after stb
            push         <= row_wr && row_pass;         // lands with the ack
            search_start <= count_wr;
            if (count_wr) begin
                row_count   <= wb_dat_w[idx_w-1:0];
                row_idx     <= '0;
                search_live <= 1'b1;
                rows_all_in <= 1'b0;                    // old level dropped with the new search
            end else begin
                if (row_wr) begin
                    row_idx <= row_idx + 1'b1;          // skipped rows still count
                end
                // sampled after the ack cycle so the last push is already in the fifo
                rows_all_in <= search_live && (row_idx >= row_count);
            end
        end
    end

    // candidate and read data, held until next use
    always_ff @(posedge clk) begin
        if (row_wr) begin
            push_data[cand_idx_lsb +: idx_w]  <= row_idx;
            push_data[cand_piv_lsb +: coef_w] <= row_piv;
            push_data[cand_rhs_lsb +: coef_w] <= row_rhs;
        end
        if (rd) begin
            wb_dat_r <= stat_word;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the pivot_row_select testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pivot_row_select -Mdir obj_dir -f pivot_row_select.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_pivot_row_select +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

// File: testbench/pivot_row_checker.sv
`timescale 1ns/1ps

module pivot_row_checker (
    input logic clk,
    input logic resetn,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack
);
    int fail_count = 0;                // assertion failures seen so far

    // slave idle while in reset
    ack_low_in_reset: assert property (@(posedge clk) !resetn |=> !wb_ack)
        else begin
            $error("wb_ack high after a reset cycle");
            fail_count++;
        end

    // ack only inside an open cycle
    ack_in_cycle: assert property (@(posedge clk) disable iff (!resetn)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $error("wb_ack high outside an open bus cycle");
            fail_count++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack high for two cycles in a row");
            fail_count++;
        end

endmodule

bind pivot_row_select pivot_row_checker u_pivot_row_checker (
    .clk    (clk),
    .resetn (resetn),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack)
);

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic resetn
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;        // 20 ns period
    end

    initial begin
        resetn = 1'b0;
        repeat (10) @(posedge clk);    // held low for 10 cycles
        resetn <= 1'b1;
    end

endmodule

// File: testbench/tb_pivot_row_select.sv
`timescale 1ns/1ps

module tb_pivot_row_select;
    import pivot_row_pkg::*;

    localparam int max_rows   = 64;
    localparam int n_burst    = 10;
    localparam int n_random   = 20;
    localparam int rows_total = 7 + 3 + n_burst * n_burst + n_random * 40;   // worst case rows
    localparam int wd_cycles  = 200 * rows_total + 2000;

    logic        clk;
    logic        resetn;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic        wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    coef_t       row_piv [max_rows];   // rows of the current search
    coef_t       row_rhs [max_rows];
    int          errors;

    tb_clock_gen u_tb_clock_gen (.clk(clk), .resetn(resetn));

    pivot_row_select u_pivot_row_select (
        .clk      (clk),
        .resetn   (resetn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // one classic cycle with inputs held until ack is seen
    task automatic transfer(input logic we, input logic adr, input logic [31:0] data,
                            output logic [31:0] rdata);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= data;
        do begin
            @(posedge clk);
        end while (!wb_ack);
        rdata  = wb_dat_r;             // registered alongside ack
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic set_row(input int i, input int piv, input int rhs);
        row_piv[i] = coef_t'(piv);
        row_rhs[i] = coef_t'(rhs);
    endtask

    // minimum rhs/piv over rows with piv > 0 and rhs >= 0 and the lower index on a tie
    task automatic model_pick(input int n, output logic exp_found, output int exp_idx);
        longint new_side;
        longint best_side;
        exp_found = 1'b0;
        exp_idx   = 0;
        for (int i = 0; i < n; i++) begin
            if (row_piv[i] > 0 && row_rhs[i] >= 0) begin
                new_side  = longint'(row_rhs[i]) * longint'(row_piv[exp_idx]);
                best_side = longint'(row_rhs[exp_idx]) * longint'(row_piv[i]);
                if (!exp_found || new_side < best_side) begin
                    exp_found = 1'b1;
                    exp_idx   = i;
                end
            end
        end
    endtask

    task automatic run_search(input int n);
        logic [31:0] stat;
        logic        exp_found;
        int          exp_idx;
        transfer(1'b1, adr_count, 32'(n), stat);
        for (int i = 0; i < n; i++) begin
            transfer(1'b1, adr_row, {row_piv[i], row_rhs[i]}, stat);
        end
        do begin
            transfer(1'b0, adr_count, '0, stat);   // poll status until done
        end while (!stat[stat_done_bit]);
        model_pick(n, exp_found, exp_idx);
        check_value("status found", int'(stat[stat_found_bit]), int'(exp_found));
        check_value("status best_idx", int'(stat[idx_w-1:0]), exp_idx);
    endtask

    initial begin
        logic [31:0] stat;
        int          proto_fails;
        int          n;
        errors   = 0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 1'b0;
        wb_dat_w = '0;
        void'($urandom(32'heeb8));
        wait (resetn === 1'b1);
        check_value("wb_ack", int'(wb_ack), 0);
        transfer(1'b0, adr_row, '0, stat);       // idle status after reset
        check_value("status done", int'(stat[stat_done_bit]), 0);
        check_value("status found", int'(stat[stat_found_bit]), 0);
        set_row(0, 0, 5);              // zero pivot
        set_row(1, -3, 6);             // negative pivot
        set_row(2, 4, -1);             // negative rhs
        set_row(3, 4, 12);
        set_row(4, 2, 4);              // ratio 2 and first of a tie
        set_row(5, 5, 20);
        set_row(6, 3, 6);              // ratio 2 again
        run_search(7);
        set_row(0, 0, 1);
        set_row(1, -2, 3);
        set_row(2, 5, -7);
        run_search(3);                 // nothing qualifies
        run_search(0);
        for (int w = 0; w < n_burst; w++) begin
            for (int i = 0; i < n_burst; i++) begin
                set_row(i, 7 + i % 3, (i == w) ? 1 : 90 + i);
            end
            run_search(n_burst);       // burst past fifo depth with the winner at row w
        end
        for (int s = 0; s < n_random; s++) begin
            n = 1 + int'($urandom % 40);
            for (int i = 0; i < n; i++) begin
                set_row(i, int'($urandom % 41) - 8, int'($urandom % 200) - 20);
            end
            run_search(n);
        end
        proto_fails = u_pivot_row_select.u_pivot_row_checker.fail_count;
        $display("check errors: %0d, protocol assertion failures: %0d", errors, proto_fails);
        if (errors == 0 && proto_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, a search never completed", wd_cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
